//--- common/lenet_pkg.sv
`default_nettype none

package lenet_pkg;

    // datapath widths.
    localparam int PIX_W  = 8;
    localparam int PROD_W = 16;
    localparam int ACC_W  = 21;  // 25 products of up to 65535.
    localparam int BIAS_W = 16;
    localparam int ACT_W  = 8;

    // window controller state.
    typedef enum logic [0:0] {
        ST_IDLE = 1'b0,
        ST_RUN  = 1'b1
    } ctrl_state_e;

    // one multiply-accumulate operation sent by conv_ctrl to mac_accum.
    typedef struct packed {
        logic             valid;
        logic [PIX_W-1:0] pixel;
        logic [PIX_W-1:0] weight;
        logic             first;  // clears the accumulator.
        logic             last;   // closes the window.
    } mac_op_t;

    // finished window sum passed from mac_accum to act_quant.
    typedef struct packed {
        logic             valid;
        logic [ACC_W-1:0] acc;
    } acc_result_t;

endpackage

`default_nettype wire

//--- mac/approx_mul8.sv
`timescale 1ns/1ps
`default_nettype none

module approx_mul8 (
    input  logic [lenet_pkg::PIX_W-1:0]  x,
    input  logic [lenet_pkg::PIX_W-1:0]  y,
    output logic [lenet_pkg::PROD_W-1:0] z
);

    import lenet_pkg::*;

    localparam int CMP_W = 13;

    logic [PIX_W-1:0][PIX_W-1:0] pp;  // pp[i] is y gated by x[i].
    logic [CMP_W-1:0]            comp1;
    logic [CMP_W-1:0]            comp2;
    logic [CMP_W-1:0]            comp3;
    logic [CMP_W-1:0]            comp4;
    logic [CMP_W-1:0]            comp5;
    logic [CMP_W-1:0]            comp6;
    logic [PROD_W-1:0]           row6;
    logic [PROD_W-1:0]           row7;

    always_comb begin
        for (int i = 0; i < PIX_W; i++) begin
            pp[i] = y & {PIX_W{x[i]}};
        end
    end

    // pruned compressor rows for the low six partial products.
    always_comb begin
        comp1 = '0;
        comp2 = '0;
        comp3 = '0;
        comp4 = '0;
        comp5 = '0;
        comp6 = '0;

        comp1[3]  = pp[0][2] | pp[1][1];
        comp1[4]  = pp[0][3] & pp[1][2];
        comp1[5]  = pp[0][4] ^ pp[1][3];
        comp1[7]  = pp[0][6] | pp[1][5];
        comp1[8]  = pp[0][7] & pp[1][6];
        comp1[9]  = pp[2][6] & pp[3][5];
        comp1[10] = pp[3][7];
        comp1[11] = pp[4][6] & pp[5][5];
        comp1[12] = pp[4][7] & pp[5][6];

        comp2[5]  = pp[2][2] & pp[3][1];
        comp2[7]  = pp[0][7] | pp[1][6];
        comp2[8]  = pp[2][5] | pp[3][4];
        comp2[9]  = pp[2][7] | pp[3][6];
        comp2[10] = pp[4][5] & pp[5][4];
        comp2[11] = pp[4][7] ^ pp[5][6];
        comp2[12] = pp[5][7];

        comp3[7]  = pp[4][2] | pp[5][1];
        comp3[8]  = pp[2][6] ^ pp[3][5];
        comp3[9]  = pp[4][5] ^ pp[5][4];
        comp3[10] = pp[4][6] ^ pp[5][5];

        comp4[7]  = pp[4][3] ^ pp[5][2];
        comp4[8]  = pp[4][3] & pp[5][2];

        // half adder split across two rows.
        comp5[8]  = pp[4][4] & pp[5][3];
        comp6[8]  = pp[4][4] | pp[5][3];
    end

    // top two rows are added exactly.
    assign row6 = {2'b00, pp[6], 6'b0};
    assign row7 = {1'b0, pp[7], 7'b0};

    assign z = row6 + row7
             + {3'b000, comp1} + {3'b000, comp2} + {3'b000, comp3}
             + {3'b000, comp4} + {3'b000, comp5} + {3'b000, comp6};  // wraps at 16 bits.

endmodule

`default_nettype wire

//--- mac/mac_accum.sv
`timescale 1ns/1ps
`default_nettype none

module mac_accum (
    input  logic                   clk,
    input  logic                   arst_n,
    input  lenet_pkg::mac_op_t     op,
    output lenet_pkg::acc_result_t result
);

    import lenet_pkg::*;

    logic [PROD_W-1:0] prod;
    logic              s1_valid;
    logic              s1_first;
    logic              s1_last;
    logic [PROD_W-1:0] s1_prod;
    logic [ACC_W-1:0]  acc_q;
    logic              res_valid;

    approx_mul8 i_approx_mul8 (
        .x (op.pixel),
        .y (op.weight),
        .z (prod)
    );

    // stage 1 holds product and flags.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
            s1_first <= 1'b0;
            s1_last  <= 1'b0;
        end else begin
            s1_valid <= op.valid;
            s1_first <= op.first;
            s1_last  <= op.last;
        end
    end

    always_ff @(posedge clk) begin
        s1_prod <= prod;
    end

    // stage 2 accumulates.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= s1_valid & s1_last;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            if (s1_first) begin
                acc_q <= {{(ACC_W-PROD_W){1'b0}}, s1_prod};  // new window.
            end else begin
                acc_q <= acc_q + {{(ACC_W-PROD_W){1'b0}}, s1_prod};
            end
        end
    end

    assign result.valid = res_valid;
    assign result.acc   = acc_q;

endmodule

`default_nettype wire

//--- hw/kernel_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module kernel_regfile #(
    parameter  int KERNEL_TAPS = 25,
    localparam int TAP_W       = $clog2(KERNEL_TAPS)
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        wt_load,
    input  logic [TAP_W-1:0]            wt_index,
    input  logic [lenet_pkg::PIX_W-1:0] wt_data,
    input  logic [TAP_W-1:0]            rd_index,
    output logic [lenet_pkg::PIX_W-1:0] rd_weight
);

    import lenet_pkg::*;

    logic [PIX_W-1:0] weights [KERNEL_TAPS];
    logic             wr_ok;
    logic             rd_ok;

    assign wr_ok = (int'(wt_index) < KERNEL_TAPS);
    assign rd_ok = (int'(rd_index) < KERNEL_TAPS);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < KERNEL_TAPS; i++) begin
                weights[i] <= '0;
            end
        end else if (wt_load && wr_ok) begin
            weights[wt_index] <= wt_data;  // out of range writes dropped.
        end
    end

    assign rd_weight = rd_ok ? weights[rd_index] : '0;

endmodule

`default_nettype wire

//--- hw/conv_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module conv_ctrl #(
    parameter  int KERNEL_TAPS = 25,
    localparam int TAP_W       = $clog2(KERNEL_TAPS)
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        start,
    input  logic                        pix_valid,
    input  logic [lenet_pkg::PIX_W-1:0] pix_data,
    output logic [TAP_W-1:0]            rd_index,
    input  logic [lenet_pkg::PIX_W-1:0] rd_weight,
    output lenet_pkg::mac_op_t          op,
    output logic                        busy
);

    import lenet_pkg::*;

    localparam logic [TAP_W-1:0] LAST_TAP = TAP_W'(KERNEL_TAPS - 1);

    ctrl_state_e      state;
    logic [TAP_W-1:0] tap_cnt;
    logic             accept;
    logic             at_last;

    assign accept  = pix_valid && (state == ST_RUN);  // idle pixels dropped.
    assign at_last = (tap_cnt == LAST_TAP);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ST_IDLE;
            tap_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state   <= ST_RUN;
                        tap_cnt <= '0;
                    end
                end
                ST_RUN: begin
                    if (accept) begin
                        if (at_last) begin
                            state   <= ST_IDLE;
                            tap_cnt <= '0;
                        end else begin
                            tap_cnt <= tap_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    assign rd_index = tap_cnt;

    // pixel goes out with its weight in the same cycle.
    assign op.valid  = accept;
    assign op.pixel  = pix_data;
    assign op.weight = rd_weight;
    assign op.first  = (tap_cnt == '0);
    assign op.last   = at_last;

    assign busy = (state == ST_RUN);  // start while busy ignored.

endmodule

`default_nettype wire

//--- hw/act_quant.sv
`timescale 1ns/1ps
`default_nettype none

module act_quant #(
    parameter int OUT_SHIFT = 8
) (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                bias_load,
    input  logic signed [lenet_pkg::BIAS_W-1:0] bias_data,
    input  lenet_pkg::acc_result_t              acc,
    output logic                                result_valid,
    output logic [lenet_pkg::ACT_W-1:0]         result_data
);

    import lenet_pkg::*;

    localparam int SUM_W = ACC_W + 2;

    logic signed [BIAS_W-1:0] bias_q;
    logic signed [SUM_W-1:0]  sum;
    logic [SUM_W-1:0]         shifted;
    logic [ACT_W-1:0]         act;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bias_q <= '0;
        end else if (bias_load) begin
            bias_q <= bias_data;
        end
    end

    assign sum = $signed({2'b00, acc.acc})
               + $signed({{(SUM_W-BIAS_W){bias_q[BIAS_W-1]}}, bias_q});
    assign shifted = $unsigned(sum) >> OUT_SHIFT;

    always_comb begin
        if (sum[SUM_W-1]) begin
            act = '0;  // relu.
        end else if (|shifted[SUM_W-1:ACT_W]) begin
            act = '1;  // saturate.
        end else begin
            act = shifted[ACT_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= acc.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (acc.valid) begin
            result_data <= act;
        end
    end

endmodule

`default_nettype wire

//--- hw/lenet_conv_unit.sv
`timescale 1ns/1ps
`default_nettype none

module lenet_conv_unit #(
    parameter  int KERNEL_TAPS = 25,
    parameter  int OUT_SHIFT   = 8,
    localparam int TAP_W       = $clog2(KERNEL_TAPS)
) (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                wt_load,
    input  logic [TAP_W-1:0]                    wt_index,
    input  logic [lenet_pkg::PIX_W-1:0]         wt_data,
    input  logic                                bias_load,
    input  logic signed [lenet_pkg::BIAS_W-1:0] bias_data,
    input  logic                                start,
    input  logic                                pix_valid,
    input  logic [lenet_pkg::PIX_W-1:0]         pix_data,
    output logic                                busy,
    output logic                                result_valid,
    output logic [lenet_pkg::ACT_W-1:0]         result_data
);

    import lenet_pkg::*;

    logic [TAP_W-1:0] rd_index;
    logic [PIX_W-1:0] rd_weight;
    mac_op_t          mac_op;
    acc_result_t      acc_res;

    conv_ctrl #(
        .KERNEL_TAPS (KERNEL_TAPS)
    ) i_conv_ctrl (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (start),
        .pix_valid (pix_valid),
        .pix_data  (pix_data),
        .rd_index  (rd_index),
        .rd_weight (rd_weight),
        .op        (mac_op),
        .busy      (busy)
    );

    kernel_regfile #(
        .KERNEL_TAPS (KERNEL_TAPS)
    ) i_kernel_regfile (
        .clk       (clk),
        .arst_n    (arst_n),
        .wt_load   (wt_load),
        .wt_index  (wt_index),
        .wt_data   (wt_data),
        .rd_index  (rd_index),
        .rd_weight (rd_weight)
    );

    mac_accum i_mac_accum (
        .clk    (clk),
        .arst_n (arst_n),
        .op     (mac_op),
        .result (acc_res)
    );

    act_quant #(
        .OUT_SHIFT (OUT_SHIFT)
    ) i_act_quant (
        .clk          (clk),
        .arst_n       (arst_n),
        .bias_load    (bias_load),
        .bias_data    (bias_data),
        .acc          (acc_res),
        .result_valid (result_valid),
        .result_data  (result_data)
    );

endmodule

`default_nettype wire

//--- dv/lenet_conv_checker.sv
`timescale 1ns/1ps
`default_nettype none

module lenet_conv_checker #(
    parameter int KERNEL_TAPS = 25
) (
    input logic clk,
    input logic arst_n,
    input logic busy,
    input logic pix_valid,
    input logic result_valid
);

    int   taps_seen;
    logic last_accept;

    // pixels only count while the window is open.
    assign last_accept = pix_valid && busy && (taps_seen == KERNEL_TAPS - 1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            taps_seen <= 0;
        end else if (pix_valid && busy) begin
            if (taps_seen == KERNEL_TAPS - 1) begin
                taps_seen <= 0;
            end else begin
                taps_seen <= taps_seen + 1;
            end
        end
    end

    a_valid_single: assert property (
        @(posedge clk) disable iff (!arst_n) result_valid |=> !result_valid
    ) else $error("result_valid high for two cycles");

    a_idle_after_reset: assert property (
        @(posedge clk) $rose(arst_n) |-> !busy
    ) else $error("busy high right after reset release");

    a_result_latency: assert property (
        @(posedge clk) disable iff (!arst_n) result_valid == $past(last_accept, 3)
    ) else $error("result_valid not 3 cycles after the last accepted pixel");

endmodule

bind lenet_conv_unit lenet_conv_checker #(
    .KERNEL_TAPS (KERNEL_TAPS)
) i_lenet_conv_checker (
    .clk          (clk),
    .arst_n       (arst_n),
    .busy         (busy),
    .pix_valid    (pix_valid),
    .result_valid (result_valid)
);

`default_nettype wire

//--- dv/lenet_conv_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lenet_conv_tb;

    import lenet_pkg::*;

    localparam int KERNEL_TAPS = 25;
    localparam int OUT_SHIFT   = 8;
    localparam int TAP_W       = $clog2(KERNEL_TAPS);
    localparam int N_TESTS     = 13;
    localparam int RES_WAIT    = 8;

    localparam int PAT_ZERO   = 0;
    localparam int PAT_POW2   = 1;
    localparam int PAT_MAX    = 2;
    localparam int PAT_RAND   = 3;
    localparam int PAT_SMALL  = 4;
    localparam int PAT_RAMP   = 5;
    localparam int PAT_KEEP   = 6;  // weights stay as loaded.
    localparam int PAT_SPARSE = 7;  // keeps the sum below saturation.

    localparam int MODE_PLAIN     = 0;
    localparam int MODE_DUP_START = 1;
    localparam int MODE_IDLE_PIX  = 2;
    localparam int MODE_B2B       = 3;  // next start as soon as busy falls.

    logic                     clk;
    logic                     arst_n;
    logic                     wt_load;
    logic [TAP_W-1:0]         wt_index;
    logic [PIX_W-1:0]         wt_data;
    logic                     bias_load;
    logic signed [BIAS_W-1:0] bias_data;
    logic                     start;
    logic                     pix_valid;
    logic [PIX_W-1:0]         pix_data;
    logic                     busy;
    logic                     result_valid;
    logic [ACT_W-1:0]         result_data;

    string            names    [N_TESTS];
    int               wt_sel   [N_TESTS];
    int               px_sel   [N_TESTS];
    int               bias_tab [N_TESTS];
    int               gap_tab  [N_TESTS];
    int               mode_tab [N_TESTS];
    logic [PIX_W-1:0] wts [KERNEL_TAPS];
    logic [PIX_W-1:0] pix [KERNEL_TAPS];
    int               exp_val_q [$];
    int               exp_idx_q [$];
    int               exp_cyc_q [$];
    int               cyc;
    int               errors;
    int               results_seen;
    int               cur_bias;
    integer           seed;

    lenet_conv_unit #(
        .KERNEL_TAPS (KERNEL_TAPS),
        .OUT_SHIFT   (OUT_SHIFT)
    ) i_dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .wt_load      (wt_load),
        .wt_index     (wt_index),
        .wt_data      (wt_data),
        .bias_load    (bias_load),
        .bias_data    (bias_data),
        .start        (start),
        .pix_valid    (pix_valid),
        .pix_data     (pix_data),
        .busy         (busy),
        .result_valid (result_valid),
        .result_data  (result_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic int bit_at(input logic b, input int pos);
        return b ? (1 << pos) : 0;
    endfunction

    // x is the pixel, y the weight.
    function automatic int approx_product(input logic [7:0] x, input logic [7:0] y);
        logic [7:0][7:0] p;
        int              s;
        for (int i = 0; i < 8; i++) begin
            p[i] = y & {8{x[i]}};
        end
        s = 64 * int'(p[6]) + 128 * int'(p[7]);  // exact upper rows.
        s += bit_at(p[0][2] | p[1][1], 3);
        s += bit_at(p[0][3] & p[1][2], 4);
        s += bit_at(p[0][4] ^ p[1][3], 5);
        s += bit_at(p[2][2] & p[3][1], 5);
        s += bit_at(p[0][6] | p[1][5], 7);
        s += bit_at(p[0][7] | p[1][6], 7);
        s += bit_at(p[4][2] | p[5][1], 7);
        s += bit_at(p[4][3] ^ p[5][2], 7);
        s += bit_at(p[0][7] & p[1][6], 8);
        s += bit_at(p[2][5] | p[3][4], 8);
        s += bit_at(p[2][6] ^ p[3][5], 8);
        s += bit_at(p[4][3] & p[5][2], 8);
        s += bit_at(p[4][4] & p[5][3], 8);
        s += bit_at(p[4][4] | p[5][3], 8);
        s += bit_at(p[2][6] & p[3][5], 9);
        s += bit_at(p[2][7] | p[3][6], 9);
        s += bit_at(p[4][5] ^ p[5][4], 9);
        s += bit_at(p[3][7], 10);
        s += bit_at(p[4][5] & p[5][4], 10);
        s += bit_at(p[4][6] ^ p[5][5], 10);
        s += bit_at(p[4][6] & p[5][5], 11);
        s += bit_at(p[4][7] ^ p[5][6], 11);
        s += bit_at(p[4][7] & p[5][6], 12);
        s += bit_at(p[5][7], 12);
        return s % 65536;  // 16 bit product wraps.
    endfunction

    function automatic int expected_act(input int bias);
        int acc;
        int sum;
        int v;
        acc = 0;
        for (int k = 0; k < KERNEL_TAPS; k++) begin
            acc += approx_product(pix[k], wts[k]);
        end
        sum = acc + bias;
        if (sum < 0) begin
            return 0;  // relu.
        end
        v = sum >>> OUT_SHIFT;
        return (v > 255) ? 255 : v;
    endfunction

    function automatic logic [PIX_W-1:0] pattern_value(input int sel, input int k);
        case (sel)
            PAT_POW2:   return 8'(1 << (k % 8));
            PAT_MAX:    return 8'hff;
            PAT_RAND:   return 8'($random(seed));
            PAT_SMALL:  return 8'(k % 4 + 1);
            PAT_RAMP:   return 8'(k * 10 + 3);
            PAT_SPARSE: return (k % 5 == 0) ? 8'($random(seed) & 32'h3f) : 8'h00;
            default:    return 8'h00;
        endcase
    endfunction

    task automatic set_entry(input int i, input string name, input int w, input int p,
                             input int b, input int g, input int m);
        names[i]    = name;
        wt_sel[i]   = w;
        px_sel[i]   = p;
        bias_tab[i] = b;
        gap_tab[i]  = g;
        mode_tab[i] = m;
    endtask

    task automatic fill_table();
        set_entry(0,  "all_zero",         PAT_KEEP,  PAT_ZERO,   0,      0, MODE_PLAIN);
        set_entry(1,  "pow2_corner",      PAT_POW2,  PAT_POW2,   0,      0, MODE_PLAIN);
        set_entry(2,  "pow2_wt_max_px",   PAT_KEEP,  PAT_MAX,    0,      0, MODE_PLAIN);
        set_entry(3,  "rand_approx_a",    PAT_RAND,  PAT_SPARSE, 0,      0, MODE_PLAIN);
        set_entry(4,  "rand_approx_b",    PAT_KEEP,  PAT_SPARSE, 0,      0, MODE_PLAIN);
        set_entry(5,  "relu_neg_bias",    PAT_SMALL, PAT_RAMP,   -30000, 0, MODE_PLAIN);
        set_entry(6,  "pos_bias",         PAT_KEEP,  PAT_RAMP,   12000,  0, MODE_PLAIN);
        set_entry(7,  "start_while_busy", PAT_KEEP,  PAT_RAMP,   12000,  0, MODE_DUP_START);
        set_entry(8,  "idle_pixels",      PAT_KEEP,  PAT_SMALL,  0,      0, MODE_IDLE_PIX);
        set_entry(9,  "gapped_pixels",    PAT_KEEP,  PAT_RAMP,   12000,  1, MODE_PLAIN);
        set_entry(10, "b2b_first",        PAT_KEEP,  PAT_SPARSE, 0,      0, MODE_B2B);
        set_entry(11, "b2b_second",       PAT_KEEP,  PAT_SMALL,  0,      0, MODE_PLAIN);
        set_entry(12, "saturate",         PAT_MAX,   PAT_MAX,    0,      0, MODE_PLAIN);
    endtask

    task automatic next_cycle();
        @(negedge clk);
        wt_load   = 1'b0;
        bias_load = 1'b0;
        start     = 1'b0;
        pix_valid = 1'b0;
    endtask

    task automatic check_result(input int t, input int exp_val, input int exp_cyc);
        if (int'(result_data) != exp_val) begin
            $display("FAILED %s: expected %0d, actual %0d", names[t], exp_val, result_data);
            errors++;
        end
        if (cyc != exp_cyc) begin
            $display("FAILED %s latency: expected cycle %0d, actual cycle %0d",
                     names[t], exp_cyc, cyc);
            errors++;
        end
    endtask

    task automatic run_entry(input int t);
        int wait_cnt;
        if (wt_sel[t] != PAT_KEEP) begin
            for (int k = 0; k < KERNEL_TAPS; k++) begin
                wts[k] = pattern_value(wt_sel[t], k);
                next_cycle();
                wt_load  = 1'b1;
                wt_index = TAP_W'(k);
                wt_data  = wts[k];
            end
        end
        for (int k = 0; k < KERNEL_TAPS; k++) begin
            pix[k] = pattern_value(px_sel[t], k);
        end
        if (mode_tab[t] == MODE_IDLE_PIX) begin
            for (int k = 0; k < 5; k++) begin
                next_cycle();
                pix_valid = 1'b1;
                pix_data  = 8'(8'h5a ^ k);  // no window open.
            end
            repeat (4) next_cycle();
        end
        exp_val_q.push_back(expected_act(bias_tab[t]));
        exp_idx_q.push_back(t);
        next_cycle();
        if (busy) begin
            $display("busy still high when %s was due to start", names[t]);
            errors++;
        end
        start = 1'b1;
        if (bias_tab[t] != cur_bias) begin
            bias_load = 1'b1;
            bias_data = BIAS_W'(bias_tab[t]);
            cur_bias  = bias_tab[t];
        end
        for (int k = 0; k < KERNEL_TAPS; k++) begin
            repeat (gap_tab[t]) next_cycle();
            next_cycle();
            pix_valid = 1'b1;
            pix_data  = pix[k];
            if (mode_tab[t] == MODE_DUP_START && k == 10) begin
                start = 1'b1;
            end
            if (k == KERNEL_TAPS - 1) begin
                exp_cyc_q.push_back(cyc + 3);
            end
        end
        if (mode_tab[t] != MODE_B2B) begin
            next_cycle();
            if (busy) begin
                $display("busy did not fall after the last pixel of %s", names[t]);
                errors++;
            end
            wait_cnt = 0;
            while (exp_val_q.size() != 0 && wait_cnt < RES_WAIT) begin
                @(posedge clk);
                wait_cnt++;
            end
            if (exp_val_q.size() != 0) begin
                $display("no result_valid for %s within %0d cycles", names[t], RES_WAIT);
                errors++;
                exp_val_q.delete();
                exp_idx_q.delete();
                exp_cyc_q.delete();
            end
        end
    endtask

    always @(negedge clk) begin
        if (arst_n && result_valid) begin
            results_seen++;
            if (exp_val_q.size() == 0 || exp_cyc_q.size() == 0) begin
                $display("result_valid pulsed with no window outstanding, data %0d",
                         result_data);
                errors++;
            end else begin
                check_result(exp_idx_q.pop_front(), exp_val_q.pop_front(),
                             exp_cyc_q.pop_front());
            end
        end
    end

    initial begin
        repeat (N_TESTS * 40 + 100) @(posedge clk);
        $display("watchdog expired after %0d cycles, run stopped", N_TESTS * 40 + 100);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        seed         = 32'hcf97;
        errors       = 0;
        results_seen = 0;
        cur_bias     = 0;
        arst_n       = 1'b0;
        wt_load      = 1'b0;
        wt_index     = '0;
        wt_data      = '0;
        bias_load    = 1'b0;
        bias_data    = '0;
        start        = 1'b0;
        pix_valid    = 1'b0;
        pix_data     = '0;
        for (int k = 0; k < KERNEL_TAPS; k++) begin
            wts[k] = '0;  // matches reset.
        end
        fill_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        for (int t = 0; t < N_TESTS; t++) begin
            run_entry(t);
        end
        next_cycle();
        $display("run done: %0d errors, %0d results seen", errors, results_seen);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- lenet_conv.f
common/lenet_pkg.sv
mac/approx_mul8.sv
mac/mac_accum.sv
hw/kernel_regfile.sv
hw/conv_ctrl.sv
hw/act_quant.sv
hw/lenet_conv_unit.sv
dv/lenet_conv_checker.sv
dv/lenet_conv_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, pass is decided from sim.log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module lenet_conv_tb -f lenet_conv.f -o lenet_conv_sim \
    && ./obj_dir/lenet_conv_sim | tee sim.log \
    && grep -q "^TEST PASS$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
